/* Bender.yml */
package:
  name: vseq

sources:
  - common/seq_pkg.sv
  - hw/sequencer/unit_tracker.sv
  - hw/sequencer/hazard_scoreboard.sv
  - hw/sequencer/issue_ctrl.sv
  - hw/vseq_top.sv
  - target: test
    files:
      - tests/tb_vseq.sv

/* common/seq_pkg.sv */
// Shared types of the vector sequencer
// Ops, units, instruction IDs, request, response and issue structs
`default_nettype none

package seq_pkg;

  //////////////////////////////////////////////////
  // Instruction IDs and registers
  //////////////////////////////////////////////////

  // Instructions in flight at most
  localparam int unsigned NrVInsn = 8;
  // ALU, multiplier, load unit, store unit
  localparam int unsigned NrUnits = 4;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  // One bit per instruction ID
  typedef logic [NrVInsn-1:0] vid_mask_t;
  // Index into the 32 vector registers
  typedef logic [4:0] vreg_t;

  //////////////////////////////////////////////////
  // Operations and units
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LOAD,
    UNIT_STORE
  } unit_e;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_MACC,
    OP_LOAD,
    OP_STORE,
    OP_MVX
  } op_e;

  // Unit that executes an operation
  function automatic unit_e unit_of(op_e op);
    case (op)
      OP_MUL, OP_MACC: return UNIT_MUL;
      OP_LOAD:         return UNIT_LOAD;
      OP_STORE:        return UNIT_STORE;
      // Move-to-scalar runs on the ALU
      default:         return UNIT_ALU;
    endcase
  endfunction

  // Dispatcher must wait for an answer on these
  function automatic logic needs_answer(op_e op);
    return op inside {OP_LOAD, OP_STORE, OP_MVX};
  endfunction

  //////////////////////////////////////////////////
  // Interface structs
  //////////////////////////////////////////////////

  // Decoded instruction from the dispatcher
  typedef struct packed {
    op_e         op;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    logic        use_vd;
    logic        use_vs1;
    logic        use_vs2;
    logic [31:0] scalar;
  } seq_req_t;

  // Answer back to the dispatcher
  typedef struct packed {
    logic        error;
    logic [31:0] data;
  } seq_resp_t;

  // Request issued to the units
  typedef struct packed {
    vid_t        id;
    op_e         op;
    unit_e       unit;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    logic        use_vd;
    logic        use_vs1;
    logic        use_vs2;
    logic [31:0] scalar;
    vid_mask_t   hazard_vs1;
    vid_mask_t   hazard_vs2;
    vid_mask_t   hazard_vd;
  } pe_req_t;

  // Retire pulses, one mask per unit
  typedef vid_mask_t [NrUnits-1:0] unit_done_t;

endpackage

`default_nettype wire

/* files.f */
common/seq_pkg.sv
hw/sequencer/unit_tracker.sv
hw/sequencer/hazard_scoreboard.sv
hw/sequencer/issue_ctrl.sv
hw/vseq_top.sv
tests/tb_vseq.sv

/* hw/sequencer/hazard_scoreboard.sv */
// Per-register last-writer and last-reader lists
// RAW, WAR and WAW hazard vectors for the incoming request
`timescale 1ns/1ps
`default_nettype none

module hazard_scoreboard (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Request currently offered by the dispatcher
  input  seq_pkg::seq_req_t  req_i,
  input  logic               alloc_i,
  input  seq_pkg::vid_t      alloc_id_i,
  // Registered running set from the tracker
  input  seq_pkg::vid_mask_t running_i,
  output seq_pkg::vid_mask_t hazard_vs1_o,
  output seq_pkg::vid_mask_t hazard_vs2_o,
  output seq_pkg::vid_mask_t hazard_vd_o
);

  localparam int unsigned NrVRegs = 2 ** $bits(seq_pkg::vreg_t);

  // One list slot per vector register
  typedef struct packed {
    seq_pkg::vid_t vid;
    logic          valid;
  } vreg_entry_t;

  vreg_entry_t [NrVRegs-1:0] wr_list_d, wr_list_q;
  vreg_entry_t [NrVRegs-1:0] rd_list_d, rd_list_q;

  // One-hot of an entry, only while its ID still runs
  function automatic seq_pkg::vid_mask_t entry_mask(vreg_entry_t entry,
                                                    seq_pkg::vid_mask_t running);
    seq_pkg::vid_mask_t mask;
    mask = '0;
    if (entry.valid && running[entry.vid]) begin
      mask[entry.vid] = 1'b1;
    end
    return mask;
  endfunction

  //////////////////////////////////////////////////
  // Hazard vectors
  //////////////////////////////////////////////////

  // RAW on each used source
  assign hazard_vs1_o = req_i.use_vs1 ? entry_mask(wr_list_q[req_i.vs1], running_i) : '0;
  assign hazard_vs2_o = req_i.use_vs2 ? entry_mask(wr_list_q[req_i.vs2], running_i) : '0;

  // WAW on the last writer, WAR on the last reader of vd
  assign hazard_vd_o = req_i.use_vd ?
    (entry_mask(wr_list_q[req_i.vd], running_i) | entry_mask(rd_list_q[req_i.vd], running_i))
    : '0;

  //////////////////////////////////////////////////
  // List update
  //////////////////////////////////////////////////

  always_comb begin
    wr_list_d = wr_list_q;
    rd_list_d = rd_list_q;
    // Drop retired entries so a reused ID starts clean
    for (int v = 0; v < NrVRegs; v++) begin
      wr_list_d[v].valid = wr_list_q[v].valid & running_i[wr_list_q[v].vid];
      rd_list_d[v].valid = rd_list_q[v].valid & running_i[rd_list_q[v].vid];
    end
    // Newly accepted instruction becomes writer and reader
    if (alloc_i) begin
      if (req_i.use_vd) begin
        wr_list_d[req_i.vd] = '{vid: alloc_id_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        rd_list_d[req_i.vs1] = '{vid: alloc_id_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        rd_list_d[req_i.vs2] = '{vid: alloc_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_list_q <= '0;
      rd_list_q <= '0;
    end else begin
      wr_list_q <= wr_list_d;
      rd_list_q <= rd_list_d;
    end
  end

endmodule

`default_nettype wire

/* hw/sequencer/issue_ctrl.sv */
// Accept/wait FSM, registered issue request
// Allocation strobe and the answer pulse to the dispatcher
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Dispatcher
  input  seq_pkg::seq_req_t           req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  output seq_pkg::seq_resp_t          resp_o,
  output logic                        resp_valid_o,
  // Units
  output seq_pkg::pe_req_t            pe_req_o,
  output logic                        pe_req_valid_o,
  input  logic                        pe_ready_i,
  // Tracker
  input  seq_pkg::vid_mask_t          running_i,
  input  seq_pkg::vid_t               free_id_i,
  input  logic                        id_avail_i,
  input  logic [seq_pkg::NrUnits-1:0] room_i,
  output logic                        alloc_o,
  output seq_pkg::vid_t               alloc_id_o,
  output seq_pkg::unit_e              alloc_unit_o,
  // Scoreboard
  input  seq_pkg::vid_mask_t          hazard_vs1_i,
  input  seq_pkg::vid_mask_t          hazard_vs2_i,
  input  seq_pkg::vid_mask_t          hazard_vd_i,
  // Answers
  input  logic                        addrgen_ack_i,
  input  logic                        addrgen_error_i,
  input  logic [31:0]                 scalar_resp_i,
  input  logic                        scalar_valid_i
);

  typedef enum logic {
    StAccept,
    StWait
  } state_e;

  state_e           state_d, state_q;
  seq_pkg::pe_req_t pe_req_d, pe_req_q;
  seq_pkg::pe_req_t pe_req_fixed;
  logic             pe_req_valid_d;
  logic             pe_stall;
  logic             answer_ldst, answer_mvx;
  seq_pkg::unit_e   req_unit;

  //////////////////////////////////////////////////
  // Acceptance
  //////////////////////////////////////////////////

  assign req_unit = seq_pkg::unit_of(req_i.op);
  // Issued request not yet taken by the units
  assign pe_stall = pe_req_valid_o && !pe_ready_i;

  assign req_ready_o  = (state_q == StAccept) && !pe_stall && id_avail_i && room_i[req_unit];
  assign alloc_o      = req_valid_i && req_ready_o;
  assign alloc_id_o   = free_id_i;
  assign alloc_unit_o = req_unit;

  // Pending instruction stays in the payload register during the wait
  assign answer_ldst = (pe_req_q.unit == seq_pkg::UNIT_LOAD ||
                        pe_req_q.unit == seq_pkg::UNIT_STORE) && addrgen_ack_i;
  assign answer_mvx  = (pe_req_q.op == seq_pkg::OP_MVX) && scalar_valid_i;

  always_comb begin
    state_d      = state_q;
    resp_o       = '0;
    resp_valid_o = 1'b0;
    case (state_q)
      StAccept: begin
        if (alloc_o && seq_pkg::needs_answer(req_i.op)) begin
          state_d = StWait;
        end
      end
      StWait: begin
        // Answer pulse, dispatcher released next cycle
        if (answer_ldst || answer_mvx) begin
          state_d      = StAccept;
          resp_valid_o = 1'b1;
          resp_o.error = answer_ldst && addrgen_error_i;
          if (answer_mvx) begin
            resp_o.data = scalar_resp_i;
          end
        end
      end
      default: state_d = StAccept;
    endcase
  end

  //////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////

  // Held hazards drop as soon as their writer or reader retires
  always_comb begin
    pe_req_o            = pe_req_q;
    pe_req_o.hazard_vs1 = pe_req_q.hazard_vs1 & running_i;
    pe_req_o.hazard_vs2 = pe_req_q.hazard_vs2 & running_i;
    pe_req_o.hazard_vd  = pe_req_q.hazard_vd & running_i;
  end

  always_comb begin
    // Hold under back-pressure
    pe_req_d       = pe_req_o;
    pe_req_valid_d = pe_stall;
    if (alloc_o) begin
      pe_req_d = '{
        id:         free_id_i,
        op:         req_i.op,
        unit:       req_unit,
        vd:         req_i.vd,
        vs1:        req_i.vs1,
        vs2:        req_i.vs2,
        use_vd:     req_i.use_vd,
        use_vs1:    req_i.use_vs1,
        use_vs2:    req_i.use_vs2,
        scalar:     req_i.scalar,
        hazard_vs1: hazard_vs1_i,
        hazard_vs2: hazard_vs2_i,
        hazard_vd:  hazard_vd_i
      };
      pe_req_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= StAccept;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    pe_req_q <= pe_req_d;
  end

  // Request without its hazard bits
  always_comb begin
    pe_req_fixed            = pe_req_q;
    pe_req_fixed.hazard_vs1 = '0;
    pe_req_fixed.hazard_vs2 = '0;
    pe_req_fixed.hazard_vd  = '0;
  end

  // Units see a stable request until they take it
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_o && !pe_ready_i |=> pe_req_valid_o && $stable(pe_req_fixed));

endmodule

`default_nettype wire

/* hw/sequencer/unit_tracker.sv */
// Running-ID bookkeeping per unit
// Free-ID search, per-unit occupancy and room, idle flag
`timescale 1ns/1ps
`default_nettype none

module unit_tracker #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Allocation from the issue controller
  input  logic                        alloc_i,
  input  seq_pkg::vid_t               alloc_id_i,
  input  seq_pkg::unit_e              alloc_unit_i,
  // Retire pulses from the units
  input  seq_pkg::unit_done_t         done_i,
  output seq_pkg::vid_mask_t          running_o,
  output seq_pkg::vid_t               free_id_o,
  output logic                        id_avail_o,
  output logic [seq_pkg::NrUnits-1:0] room_o,
  output logic                        idle_o
);

  // Wide enough to count every ID on one unit
  localparam int unsigned CntWidth = $clog2(seq_pkg::NrVInsn + 1);

  //////////////////////////////////////////////////
  // Per-unit running masks
  //////////////////////////////////////////////////

  seq_pkg::unit_done_t                       unit_running_d, unit_running_q;
  logic [seq_pkg::NrUnits-1:0][CntWidth-1:0] unit_cnt;

  // Retire first, then mark the new ID
  // A freshly allocated ID is never retiring in the same cycle
  always_comb begin
    unit_running_d = unit_running_q & ~done_i;
    if (alloc_i) begin
      unit_running_d[alloc_unit_i][alloc_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_running_q <= '0;
    end else begin
      unit_running_q <= unit_running_d;
    end
  end

  // Overall running set
  always_comb begin
    running_o = '0;
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      running_o |= unit_running_q[u];
    end
  end

  assign idle_o     = ~|running_o;
  assign id_avail_o = ~&running_o;

  // Lowest clear bit wins
  always_comb begin
    free_id_o = '0;
    for (int i = seq_pkg::NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        free_id_o = seq_pkg::vid_t'(i);
      end
    end
  end

  //////////////////////////////////////////////////
  // Occupancy
  //////////////////////////////////////////////////

  // Population count of each unit mask
  always_comb begin
    for (int u = 0; u < seq_pkg::NrUnits; u++) begin
      unit_cnt[u] = '0;
      for (int i = 0; i < seq_pkg::NrVInsn; i++) begin
        unit_cnt[u] += CntWidth'(unit_running_q[u][i]);
      end
    end
  end

  for (genvar u = 0; u < seq_pkg::NrUnits; u++) begin : g_room
    assign room_o[u] = unit_cnt[u] < QueueDepth;
  end

  // Issue side must only hand out free IDs
  a_alloc_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_i |-> !running_o[alloc_id_i]);

  // Units only retire what they were given
  a_done_running: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (done_i & ~unit_running_q) == '0);

endmodule

`default_nettype wire

/* hw/vseq_top.sv */
// Vector instruction sequencer top level
// Tracker and scoreboard feeding the issue controller
`timescale 1ns/1ps
`default_nettype none

module vseq_top #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Dispatcher
  input  seq_pkg::seq_req_t   req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output seq_pkg::seq_resp_t  resp_o,
  output logic                resp_valid_o,
  output logic                idle_o,
  // Units
  output seq_pkg::pe_req_t    pe_req_o,
  output logic                pe_req_valid_o,
  input  logic                pe_ready_i,
  input  seq_pkg::unit_done_t done_i,
  // Answers
  input  logic                addrgen_ack_i,
  input  logic                addrgen_error_i,
  input  logic [31:0]         scalar_resp_i,
  input  logic                scalar_valid_i
);

  seq_pkg::vid_mask_t          running;
  seq_pkg::vid_t               free_id;
  logic                        id_avail;
  logic [seq_pkg::NrUnits-1:0] room;
  logic                        alloc;
  seq_pkg::vid_t               alloc_id;
  seq_pkg::unit_e              alloc_unit;
  seq_pkg::vid_mask_t          hazard_vs1, hazard_vs2, hazard_vd;

  unit_tracker #(
    .QueueDepth (QueueDepth)
  ) i_unit_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .alloc_i      (alloc),
    .alloc_id_i   (alloc_id),
    .alloc_unit_i (alloc_unit),
    .done_i       (done_i),
    .running_o    (running),
    .free_id_o    (free_id),
    .id_avail_o   (id_avail),
    .room_o       (room),
    .idle_o       (idle_o)
  );

  hazard_scoreboard i_hazard_scoreboard (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .alloc_i      (alloc),
    .alloc_id_i   (alloc_id),
    .running_i    (running),
    .hazard_vs1_o (hazard_vs1),
    .hazard_vs2_o (hazard_vs2),
    .hazard_vd_o  (hazard_vd)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .resp_o          (resp_o),
    .resp_valid_o    (resp_valid_o),
    .pe_req_o        (pe_req_o),
    .pe_req_valid_o  (pe_req_valid_o),
    .pe_ready_i      (pe_ready_i),
    .running_i       (running),
    .free_id_i       (free_id),
    .id_avail_i      (id_avail),
    .room_i          (room),
    .alloc_o         (alloc),
    .alloc_id_o      (alloc_id),
    .alloc_unit_o    (alloc_unit),
    .hazard_vs1_i    (hazard_vs1),
    .hazard_vs2_i    (hazard_vs2),
    .hazard_vd_i     (hazard_vd),
    .addrgen_ack_i   (addrgen_ack_i),
    .addrgen_error_i (addrgen_error_i),
    .scalar_resp_i   (scalar_resp_i),
    .scalar_valid_i  (scalar_valid_i)
  );

endmodule

`default_nettype wire

/* tests/tb_vseq.sv */
// Testbench for the vector sequencer
// Stimulus table, running-ID model, watchdog and reporting
`timescale 1ns/1ps
`default_nettype none

module tb_vseq;

  localparam int unsigned ClkPeriod  = 40;
  localparam int unsigned QueueDepth = 2;
  localparam int unsigned NrRows     = 9;

  // Request, retire and answer stimulus plus the expected issue
  typedef struct packed {
    seq_pkg::op_e        op;
    seq_pkg::unit_e      unit;
    seq_pkg::vreg_t      vd;
    seq_pkg::vreg_t      vs1;
    seq_pkg::vreg_t      vs2;
    logic [2:0]          use_regs;
    seq_pkg::unit_done_t pre_done;
    seq_pkg::unit_done_t late_done;
    logic                err;
    logic [3:0]          stall;
    seq_pkg::vid_t       exp_id;
    seq_pkg::vid_mask_t  exp_vs1;
    seq_pkg::vid_mask_t  exp_vs2;
    seq_pkg::vid_mask_t  exp_vd;
  } row_t;

  logic                clk_i;
  logic                rst_ni;
  seq_pkg::seq_req_t   req_i;
  logic                req_valid_i;
  logic                req_ready_o;
  seq_pkg::seq_resp_t  resp_o;
  logic                resp_valid_o;
  logic                idle_o;
  seq_pkg::pe_req_t    pe_req_o;
  logic                pe_req_valid_o;
  logic                pe_ready_i;
  seq_pkg::unit_done_t done_i;
  logic                addrgen_ack_i;
  logic                addrgen_error_i;
  logic [31:0]         scalar_resp_i;
  logic                scalar_valid_i;

  row_t                rows [NrRows];
  // Model of the IDs running on each unit
  seq_pkg::unit_done_t model_running;
  logic [31:0]         seed;
  int                  errors;
  int                  rows_failed;

  vseq_top #(
    .QueueDepth (QueueDepth)
  ) i_vseq_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .resp_o          (resp_o),
    .resp_valid_o    (resp_valid_o),
    .idle_o          (idle_o),
    .pe_req_o        (pe_req_o),
    .pe_req_valid_o  (pe_req_valid_o),
    .pe_ready_i      (pe_ready_i),
    .done_i          (done_i),
    .addrgen_ack_i   (addrgen_ack_i),
    .addrgen_error_i (addrgen_error_i),
    .scalar_resp_i   (scalar_resp_i),
    .scalar_valid_i  (scalar_valid_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("Fail t=%0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error t=%0t %s", $time, what);
      errors++;
    end
  endtask

  task automatic set_row(input int idx, input seq_pkg::op_e op, input seq_pkg::unit_e unit,
                         input seq_pkg::vreg_t vd, input seq_pkg::vreg_t vs1,
                         input seq_pkg::vreg_t vs2, input logic [2:0] use_regs,
                         input seq_pkg::unit_done_t pre_done,
                         input seq_pkg::unit_done_t late_done, input logic err,
                         input logic [3:0] stall, input seq_pkg::vid_t exp_id,
                         input seq_pkg::vid_mask_t exp_vs1, input seq_pkg::vid_mask_t exp_vs2,
                         input seq_pkg::vid_mask_t exp_vd);
    rows[idx] = '{op, unit, vd, vs1, vs2, use_regs, pre_done, late_done, err, stall,
                  exp_id, exp_vs1, exp_vs2, exp_vd};
  endtask

  // One-cycle retire pulse, mirrored into the model
  task automatic drive_done(input seq_pkg::unit_done_t mask);
    @(posedge clk_i);
    done_i <= mask;
    @(posedge clk_i);
    done_i <= '0;
    model_running = model_running & ~mask;
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  // Done masks hold ALU in bits 7:0, MUL 15:8, LOAD 23:16, STORE 31:24
  task automatic fill_table();
    set_row(0, seq_pkg::OP_ADD, seq_pkg::UNIT_ALU, 5'd1, 5'd2, 5'd3, 3'b111,
            32'h0, 32'h0, 1'b0, 4'd0, 3'd0, 8'h00, 8'h00, 8'h00);
    // RAW on v1 from ID 0
    set_row(1, seq_pkg::OP_SUB, seq_pkg::UNIT_ALU, 5'd4, 5'd1, 5'd5, 3'b111,
            32'h0, 32'h0, 1'b0, 4'd0, 3'd1, 8'h01, 8'h00, 8'h00);
    // WAR on v2, read by ID 0
    set_row(2, seq_pkg::OP_MUL, seq_pkg::UNIT_MUL, 5'd2, 5'd6, 5'd7, 3'b111,
            32'h0, 32'h0, 1'b0, 4'd0, 3'd2, 8'h00, 8'h00, 8'h01);
    // WAW with ID 0 and WAR with ID 1 on v1
    set_row(3, seq_pkg::OP_MUL, seq_pkg::UNIT_MUL, 5'd1, 5'd8, 5'd9, 3'b111,
            32'h0, 32'h0, 1'b0, 4'd0, 3'd3, 8'h00, 8'h00, 8'h03);
    // Third MUL blocked until ID 2 retires, then reuses ID 2
    set_row(4, seq_pkg::OP_MACC, seq_pkg::UNIT_MUL, 5'd10, 5'd4, 5'd11, 3'b111,
            32'h0, 32'h0000_0400, 1'b0, 4'd0, 3'd2, 8'h02, 8'h00, 8'h00);
    // Writer of v4 retired, only the WAR from ID 2 stays
    set_row(5, seq_pkg::OP_LOAD, seq_pkg::UNIT_LOAD, 5'd4, 5'd0, 5'd0, 3'b100,
            32'h0000_0003, 32'h0, 1'b1, 4'd0, 3'd0, 8'h00, 8'h00, 8'h04);
    set_row(6, seq_pkg::OP_STORE, seq_pkg::UNIT_STORE, 5'd0, 5'd4, 5'd0, 3'b010,
            32'h0, 32'h0, 1'b0, 4'd0, 3'd1, 8'h01, 8'h00, 8'h00);
    // Everything retires first, so the sequencer goes idle
    set_row(7, seq_pkg::OP_MVX, seq_pkg::UNIT_ALU, 5'd0, 5'd10, 5'd0, 3'b010,
            32'h0201_0c00, 32'h0, 1'b0, 4'd3, 3'd0, 8'h00, 8'h00, 8'h00);
    set_row(8, seq_pkg::OP_ADD, seq_pkg::UNIT_ALU, 5'd3, 5'd4, 5'd10, 3'b111,
            32'h0000_0001, 32'h0, 1'b0, 4'd0, 3'd0, 8'h00, 8'h00, 8'h00);
  endtask

  //////////////////////////////////////////////////
  // Row sequence
  //////////////////////////////////////////////////

  task automatic run_row(input int idx);
    row_t             r;
    seq_pkg::pe_req_t held;
    logic             answer;
    logic [31:0]      data;
    logic [31:0]      req_scalar;
    int               start_errors;
    r            = rows[idx];
    start_errors = errors;
    answer = (r.op == seq_pkg::OP_LOAD) || (r.op == seq_pkg::OP_STORE) ||
             (r.op == seq_pkg::OP_MVX);
    if (r.pre_done != '0) begin
      drive_done(r.pre_done);
      @(negedge clk_i);
      check_eq("idle_o", idle_o, model_running == '0);
    end
    seed       = xorshift(seed);
    req_scalar = seed;
    @(posedge clk_i);
    req_i <= '{op: r.op, vd: r.vd, vs1: r.vs1, vs2: r.vs2, use_vd: r.use_regs[2],
               use_vs1: r.use_regs[1], use_vs2: r.use_regs[0], scalar: req_scalar};
    req_valid_i <= 1'b1;
    pe_ready_i  <= (r.stall == 0);
    if (r.late_done != '0) begin
      // Unit queue is full
      repeat (3) begin
        @(negedge clk_i);
        check_true(!req_ready_o, "req_ready_o high while the unit queue is full");
      end
      drive_done(r.late_done);
    end
    do begin
      @(negedge clk_i);
    end while (!req_ready_o);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    model_running[r.unit][r.exp_id] = 1'b1;
    // Issue shows up one cycle after the accept
    @(negedge clk_i);
    check_true(pe_req_valid_o, "no issued request one cycle after the accept");
    check_eq("pe_req_o.id", pe_req_o.id, r.exp_id);
    check_eq("pe_req_o.op", pe_req_o.op, r.op);
    check_eq("pe_req_o.unit", pe_req_o.unit, r.unit);
    check_eq("pe_req_o.vd", pe_req_o.vd, r.vd);
    check_eq("pe_req_o.vs1", pe_req_o.vs1, r.vs1);
    check_eq("pe_req_o.vs2", pe_req_o.vs2, r.vs2);
    check_eq("pe_req_o.use_vd", pe_req_o.use_vd, r.use_regs[2]);
    check_eq("pe_req_o.use_vs1", pe_req_o.use_vs1, r.use_regs[1]);
    check_eq("pe_req_o.use_vs2", pe_req_o.use_vs2, r.use_regs[0]);
    check_eq("pe_req_o.scalar", pe_req_o.scalar, req_scalar);
    check_eq("pe_req_o.hazard_vs1", pe_req_o.hazard_vs1, r.exp_vs1);
    check_eq("pe_req_o.hazard_vs2", pe_req_o.hazard_vs2, r.exp_vs2);
    check_eq("pe_req_o.hazard_vd", pe_req_o.hazard_vd, r.exp_vd);
    check_eq("idle_o", idle_o, 1'b0);
    if (answer) begin
      check_true(!req_ready_o, "req_ready_o high while waiting for an answer");
    end
    if (r.stall != 0) begin
      held = pe_req_o;
      repeat (r.stall) begin
        @(negedge clk_i);
        check_true(pe_req_valid_o, "pe_req_valid_o dropped under back-pressure");
        assert (pe_req_o == held) else begin
          $display("Fail t=%0t pe_req_o got %h expected %h", $time, pe_req_o, held);
          errors++;
        end
      end
      @(posedge clk_i);
      pe_ready_i <= 1'b1;
    end
    if (answer) begin
      seed = xorshift(seed);
      data = seed;
      @(posedge clk_i);
      if (r.op == seq_pkg::OP_MVX) begin
        scalar_valid_i <= 1'b1;
        scalar_resp_i  <= data;
      end else begin
        addrgen_ack_i   <= 1'b1;
        addrgen_error_i <= r.err;
      end
      do begin
        @(negedge clk_i);
        check_true(!req_ready_o, "req_ready_o high before the answer");
      end while (!resp_valid_o);
      check_eq("resp_o.error", resp_o.error, (r.op == seq_pkg::OP_MVX) ? 1'b0 : r.err);
      if (r.op == seq_pkg::OP_MVX) begin
        check_eq("resp_o.data", resp_o.data, data);
      end
      @(posedge clk_i);
      scalar_valid_i  <= 1'b0;
      addrgen_ack_i   <= 1'b0;
      addrgen_error_i <= 1'b0;
      // Answer is a single pulse, dispatcher free again right after
      @(negedge clk_i);
      check_true(!resp_valid_o, "resp_valid_o stayed high after the answer");
      check_true(req_ready_o, "req_ready_o still low after the answer");
    end
    if (errors == start_errors) begin
      $display("Row %0d (op %0d, ID %0d) passed", idx, r.op, r.exp_id);
    end else begin
      $display("Row %0d (op %0d, ID %0d) failed", idx, r.op, r.exp_id);
      rows_failed++;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    pe_ready_i      = 1'b1;
    done_i          = '0;
    addrgen_ack_i   = 1'b0;
    addrgen_error_i = 1'b0;
    scalar_resp_i   = '0;
    scalar_valid_i  = 1'b0;
    seed            = 32'd78751;
    model_running   = '0;
    errors          = 0;
    rows_failed     = 0;
    fill_table();
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_eq("pe_req_valid_o", pe_req_valid_o, 1'b0);
    check_eq("resp_valid_o", resp_valid_o, 1'b0);
    check_eq("idle_o", idle_o, 1'b1);
    for (int i = 0; i < NrRows; i++) begin
      run_row(i);
    end
    // Retire the last ADD
    drive_done(32'h0000_0001);
    @(negedge clk_i);
    check_eq("idle_o", idle_o, model_running == '0);
    $display("%0d rows, %0d passed, %0d failed, %0d errors",
             NrRows, NrRows - rows_failed, rows_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Each row gets 50 cycles, plus reset
  initial begin
    #((NrRows * 50 + 20) * ClkPeriod);
    $display("Timeout: the sequencer stopped answering");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
